/* src.f */
source/pipe_pkg.sv
source/register_file.sv
source/decode_stage.sv
source/execute_stage.sv
source/pipeline_control.sv
source/pipeline_top.sv
dv/tb_clock.sv
dv/pipeline_assert.sv
dv/tb_pipeline.sv

/* Makefile */
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -j 0
TOP       = tb_pipeline
FILELIST  = src.f
BUILD_DIR = obj_dir
PASS_MSG  = >>> PASS

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator and run the simulation"
	@echo "  clean  remove the build directory"

$(BUILD_DIR)/V$(TOP): $(FILELIST) $(shell cat $(FILELIST))
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

test: $(BUILD_DIR)/V$(TOP)
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qxF '$(PASS_MSG)'

clean:
	rm -rf $(BUILD_DIR)

/* dv/tb_pipeline.sv */
module tb_pipeline;
   timeunit 1ns;
   timeprecision 100ps;

   localparam int random_count  = 200;
   localparam int timeout_limit = 100;

   logic              clk;
   logic              rst_n;
   logic              instr_req;
   pipe_pkg::instr_t  instr;
   logic              instr_ack;
   logic              result_req;
   logic              result_ack;
   pipe_pkg::reg_id_t result_dr;
   pipe_pkg::word_t   result_data;

   integer seed = 5;
   int     value_errors = 0;
   int     other_errors = 0;
   int     accepted = 0;
   int     received = 0;

   // Program in issue order and the expected result of each entry
   pipe_pkg::instr_t  prog[$];
   string             prog_test[$];
   pipe_pkg::reg_id_t exp_dr[$];
   pipe_pkg::word_t   exp_data[$];
   pipe_pkg::reg_id_t recent_dr[$];
   pipe_pkg::word_t   model_regs [pipe_pkg::reg_count];

   tb_clock clock_i (
      .clk (clk)
   );

   pipeline_top pipeline_top_i (
      .clk         (clk),
      .rst_n       (rst_n),
      .instr_req   (instr_req),
      .instr       (instr),
      .instr_ack   (instr_ack),
      .result_req  (result_req),
      .result_ack  (result_ack),
      .result_dr   (result_dr),
      .result_data (result_data)
   );

   bind pipeline_control pipeline_assert assert_i (
      .clk        (clk),
      .rst_n      (rst_n),
      .instr_req  (instr_req),
      .instr_ack  (instr_ack),
      .result_req (result_req),
      .result_ack (result_ack)
   );

   function automatic int rand_below(int n);
      return int'($unsigned($random(seed)) % n);
   endfunction

   // Result as the ALU rules define it
   function automatic pipe_pkg::word_t alu_model(pipe_pkg::alu_op_t op, pipe_pkg::word_t a,
                                                 pipe_pkg::word_t b);
      case (op)
         pipe_pkg::add:    return a + b;
         pipe_pkg::sub:    return a - b;
         pipe_pkg::and_op: return a & b;
         pipe_pkg::or_op:  return a | b;
         pipe_pkg::xor_op: return a ^ b;
         pipe_pkg::shl:    return a << b[4:0];
         pipe_pkg::shr:    return a >> b[4:0];
         default:          return b;
      endcase
   endfunction

   // Sources lean toward the last few destinations to provoke hazards
   function automatic int pick_src();
      int r;
      r = rand_below(8);
      if (recent_dr.size() > 0 && r < 5) begin
         return int'(recent_dr[r % recent_dr.size()]);
      end
      return rand_below(8);
   endfunction

   task automatic add_instr(input string test, input logic imm_sel, input pipe_pkg::alu_op_t op,
                            input int dr, input int sr1, input int sr2, input int imm);
      pipe_pkg::instr_t w;
      pipe_pkg::word_t  a;
      pipe_pkg::word_t  b;
      int               junk;
      junk     = rand_below(8);
      w        = '0;
      w[31]    = imm_sel;
      w[30:28] = op;
      w[27:25] = dr[2:0];
      w[24:22] = sr1[2:0];
      w[21:19] = sr2[2:0];
      // Unused bits carry noise
      w[18:16] = junk[2:0];
      w[15:0]  = imm[15:0];
      a = model_regs[sr1[2:0]];
      b = imm_sel ? {{16{imm[15]}}, imm[15:0]} : model_regs[sr2[2:0]];
      model_regs[dr[2:0]] = alu_model(op, a, b);
      prog.push_back(w);
      prog_test.push_back(test);
      exp_dr.push_back(dr[2:0]);
      exp_data.push_back(model_regs[dr[2:0]]);
      recent_dr.push_front(dr[2:0]);
      if (recent_dr.size() > 3) begin
         void'(recent_dr.pop_back());
      end
   endtask

   task automatic build_program();
      pipe_pkg::alu_op_t opv;
      for (int r = 0; r < 8; r++) begin
         add_instr("reset_read", 1'b1, pipe_pkg::or_op, r, r, 0, 0);
      end
      for (int r = 1; r < 8; r++) begin
         add_instr("load", 1'b1, pipe_pkg::mov, r, 0, 0, r * 7919 - 20000);
      end
      for (int op = 0; op < 8; op++) begin
         opv = pipe_pkg::alu_op_t'(op[2:0]);
         add_instr($sformatf("%s_reg", opv.name()), 1'b0, opv, op, (op + 1) % 8, (op + 3) % 8, 0);
         add_instr($sformatf("%s_imm", opv.name()), 1'b1, opv, (op + 2) % 8, (op + 5) % 8, 0,
                   32768 + op * 1111);
      end
      // Chains where each source is the previous destination
      for (int i = 0; i < 6; i++) begin
         add_instr("dependent", 1'b1, pipe_pkg::add, 2, 2, 0, i + 1);
         add_instr("dependent", 1'b0, pipe_pkg::add, 3, 2, 3, 0);
      end
      for (int i = 0; i < random_count; i++) begin
         add_instr("random", rand_below(2) == 1, pipe_pkg::alu_op_t'(3'(rand_below(8))),
                   rand_below(8), pick_src(), pick_src(), rand_below(65536));
      end
   endtask

   task automatic next_cycle();
      @(posedge clk);
      #1;
   endtask

   task automatic finish_run();
      $display("Done: %0d accepted, %0d results, %0d value errors, %0d other errors",
               accepted, received, value_errors, other_errors);
      if (value_errors == 0 && other_errors == 0) begin
         $display(">>> PASS");
      end else begin
         $display(">>> FAIL");
      end
      $finish;
   endtask

   task automatic report_timeout(input string what);
      other_errors++;
      $display("Timeout: %s", what);
   endtask

   task automatic check_reset_outputs(input string test);
      assert (instr_ack === 1'b0) else begin
         value_errors++;
         $display("Error %s: instr_ack expected 0, actual %b", test, instr_ack);
      end
      assert (result_req === 1'b0) else begin
         value_errors++;
         $display("Error %s: result_req expected 0, actual %b", test, result_req);
      end
   endtask

   task automatic check_result();
      string             test;
      pipe_pkg::reg_id_t dr_exp;
      pipe_pkg::word_t   data_exp;
      received++;
      assert (exp_dr.size() > 0) else begin
         other_errors++;
         $display("A result arrived after all expected results were seen");
      end
      if (exp_dr.size() > 0) begin
         test     = prog_test.pop_front();
         dr_exp   = exp_dr.pop_front();
         data_exp = exp_data.pop_front();
         assert (result_dr === dr_exp) else begin
            value_errors++;
            $display("Error %s: result_dr expected %0d, actual %0d", test, dr_exp, result_dr);
         end
         assert (result_data === data_exp) else begin
            value_errors++;
            $display("Error %s: result_data expected %h, actual %h", test, data_exp, result_data);
         end
      end
   endtask

   task automatic produce();
      int n;
      for (int i = 0; i < prog.size(); i++) begin
         n = 0;
         while (instr_ack !== 1'b0 && n < timeout_limit) begin
            next_cycle();
            n++;
         end
         if (instr_ack !== 1'b0) begin
            report_timeout("instr_ack did not fall after instr_req was lowered");
            return;
         end
         instr     = prog[i];
         instr_req = 1'b1;
         n = 0;
         while (instr_ack !== 1'b1 && n < timeout_limit) begin
            next_cycle();
            n++;
         end
         if (instr_ack !== 1'b1) begin
            report_timeout("instruction was never acknowledged");
            return;
         end
         accepted++;
         instr_req = 1'b0;
      end
   endtask

   task automatic consume();
      int n;
      int delay;
      int hold;
      while (received < prog.size()) begin
         n = 0;
         while (result_req !== 1'b1 && n < timeout_limit) begin
            next_cycle();
            n++;
         end
         if (result_req !== 1'b1) begin
            report_timeout("no result handshake arrived");
            return;
         end
         check_result();
         delay = rand_below(6);
         repeat (delay) begin
            next_cycle();
         end
         result_ack = 1'b1;
         n = 0;
         while (result_req !== 1'b0 && n < timeout_limit) begin
            next_cycle();
            n++;
         end
         if (result_req !== 1'b0) begin
            report_timeout("result_req stayed high after result_ack");
            return;
         end
         // Ack lingers so writeback must keep waiting for it to drop
         hold = rand_below(3);
         repeat (hold) begin
            next_cycle();
            assert (result_req === 1'b0) else begin
               other_errors++;
               $display("A new result was offered before result_ack was lowered");
            end
         end
         result_ack = 1'b0;
      end
   endtask

   initial begin
      rst_n      = 1'b0;
      instr_req  = 1'b0;
      instr      = '0;
      result_ack = 1'b0;
      for (int r = 0; r < pipe_pkg::reg_count; r++) begin
         model_regs[r] = '0;
      end
      build_program();
      repeat (4) begin
         next_cycle();
         check_reset_outputs("reset");
      end
      rst_n = 1'b1;
      repeat (2) begin
         next_cycle();
         check_reset_outputs("after_reset");
      end
      fork
         produce();
         consume();
      join
      // Pipeline must stay quiet once every result is taken
      repeat (10) begin
         next_cycle();
         assert (result_req === 1'b0) else begin
            other_errors++;
            $display("An extra result was offered after the last instruction");
         end
      end
      assert (accepted == prog.size() && received == accepted && exp_dr.size() == 0) else begin
         other_errors++;
         $display("Result count does not match: %0d issued, %0d accepted, %0d results",
                  prog.size(), accepted, received);
      end
      finish_run();
   end

endmodule

/* dv/pipeline_assert.sv */
module pipeline_assert (
   input logic clk,
   input logic rst_n,
   input logic instr_req,
   input logic instr_ack,
   input logic result_req,
   input logic result_ack
);
   timeunit 1ns;
   timeprecision 100ps;

   // Request held until the capture is acknowledged
   instr_req_held : assert property (@(posedge clk) disable iff (!rst_n)
      instr_req && !instr_ack |=> instr_req || instr_ack)
      else $error("instr_req fell before instr_ack was raised");

   // No acknowledge without a pending request
   instr_ack_needs_req : assert property (@(posedge clk) disable iff (!rst_n)
      !instr_ack && !instr_req |=> !instr_ack)
      else $error("instr_ack rose without instr_req");

   // Result offered until the consumer answers
   result_req_held : assert property (@(posedge clk) disable iff (!rst_n)
      result_req && !result_ack |=> result_req)
      else $error("result_req fell before result_ack was seen");

   // Next result waits for the ack to drop
   result_req_quiet : assert property (@(posedge clk) disable iff (!rst_n)
      !result_req && result_ack |=> !result_req)
      else $error("result_req rose while result_ack was still high");

endmodule

/* dv/tb_clock.sv */
module tb_clock (
   output logic clk
);
   timeunit 1ns;
   timeprecision 100ps;

   initial begin
      clk = 1'b0;
   end

   // 20 ns period, first rising edge at 10 ns
   always begin
      #10 clk = ~clk;
   end

endmodule

/* source/pipeline_top.sv */
module pipeline_top (
   input  logic              clk,
   input  logic              rst_n,
   input  logic              instr_req,
   input  pipe_pkg::instr_t  instr,
   output logic              instr_ack,
   output logic              result_req,
   input  logic              result_ack,
   output pipe_pkg::reg_id_t result_dr,
   output pipe_pkg::word_t   result_data
);

   logic              de_load;
   logic              ex_load;
   logic              wb_load;
   logic              rf_we;
   pipe_pkg::reg_id_t de_dr;
   pipe_pkg::reg_id_t de_sr1;
   pipe_pkg::reg_id_t de_sr2;
   logic              de_imm_sel;
   pipe_pkg::alu_op_t de_op;
   pipe_pkg::word_t   de_imm_ext;
   pipe_pkg::reg_id_t ex_dr;
   pipe_pkg::word_t   rd_data1;
   pipe_pkg::word_t   rd_data2;

   pipeline_control control_i (
      .clk        (clk),
      .rst_n      (rst_n),
      .instr_req  (instr_req),
      .instr_ack  (instr_ack),
      .result_req (result_req),
      .result_ack (result_ack),
      .de_dr      (de_dr),
      .de_sr1     (de_sr1),
      .de_sr2     (de_sr2),
      .de_imm_sel (de_imm_sel),
      .ex_dr      (ex_dr),
      .wb_dr      (result_dr),
      .de_load    (de_load),
      .ex_load    (ex_load),
      .wb_load    (wb_load),
      .rf_we      (rf_we)
   );

   decode_stage decode_i (
      .clk     (clk),
      .rst_n   (rst_n),
      .de_load (de_load),
      .instr   (instr),
      .sr1     (de_sr1),
      .sr2     (de_sr2),
      .dr      (de_dr),
      .imm_sel (de_imm_sel),
      .op      (de_op),
      .imm_ext (de_imm_ext)
   );

   // Writeback latch feeds the write port directly
   register_file regfile_i (
      .clk      (clk),
      .rst_n    (rst_n),
      .rd_id1   (de_sr1),
      .rd_id2   (de_sr2),
      .rd_data1 (rd_data1),
      .rd_data2 (rd_data2),
      .we       (rf_we),
      .wr_id    (result_dr),
      .wr_data  (result_data)
   );

   execute_stage execute_i (
      .clk      (clk),
      .rst_n    (rst_n),
      .ex_load  (ex_load),
      .wb_load  (wb_load),
      .op       (de_op),
      .imm_sel  (de_imm_sel),
      .imm_ext  (de_imm_ext),
      .dr       (de_dr),
      .rd_data1 (rd_data1),
      .rd_data2 (rd_data2),
      .ex_dr    (ex_dr),
      .wb_dr    (result_dr),
      .wb_data  (result_data)
   );

endmodule

/* source/pipeline_control.sv */
module pipeline_control (
   input  logic              clk,
   input  logic              rst_n,
   // Instruction handshake
   input  logic              instr_req,
   output logic              instr_ack,
   // Result handshake
   output logic              result_req,
   input  logic              result_ack,
   // Register numbers for the dependency check
   input  pipe_pkg::reg_id_t de_dr,
   input  pipe_pkg::reg_id_t de_sr1,
   input  pipe_pkg::reg_id_t de_sr2,
   input  logic              de_imm_sel,
   input  pipe_pkg::reg_id_t ex_dr,
   input  pipe_pkg::reg_id_t wb_dr,
   // Latch enables
   output logic              de_load,
   output logic              ex_load,
   output logic              wb_load,
   output logic              rf_we
);

   logic de_valid;
   logic ex_valid;
   logic wb_valid;
   logic wb_free;
   logic ex_ready;
   logic de_ready;
   logic hazard;
   logic wb_same_dr;

   // One bit per register with a write still in execute or writeback
   logic [pipe_pkg::reg_count-1:0] pending;

   // Writeback only refills once the consumer has dropped its ack
   assign wb_free  = !wb_valid && !result_ack;
   assign wb_load  = ex_valid && wb_free;
   assign ex_ready = !ex_valid || wb_load;

   // Hold decode while a source still has an older write in flight
   assign hazard  = pending[de_sr1] || (!de_imm_sel && pending[de_sr2]);
   assign ex_load = de_valid && !hazard && ex_ready;

   assign de_ready = !de_valid || ex_load;
   assign de_load  = instr_req && !instr_ack && de_ready;

   // Result is offered for as long as writeback holds one
   assign result_req = wb_valid;
   assign rf_we      = wb_valid && result_ack;

   // Younger writer in execute keeps the register marked
   assign wb_same_dr = ex_valid && (ex_dr == wb_dr);

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         de_valid <= 1'b0;
         ex_valid <= 1'b0;
         wb_valid <= 1'b0;
      end else begin
         if (de_load) begin
            de_valid <= 1'b1;
         end else if (ex_load) begin
            de_valid <= 1'b0;
         end
         if (ex_load) begin
            ex_valid <= 1'b1;
         end else if (wb_load) begin
            ex_valid <= 1'b0;
         end
         if (wb_load) begin
            wb_valid <= 1'b1;
         end else if (rf_we) begin
            wb_valid <= 1'b0;
         end
      end
   end

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         pending <= '0;
      end else begin
         if (rf_we && !wb_same_dr) begin
            pending[wb_dr] <= 1'b0;
         end
         // A new writer entering execute wins over a clear
         if (ex_load) begin
            pending[de_dr] <= 1'b1;
         end
      end
   end

   // Ack rises with the capture and falls once req is seen low
   always_ff @(posedge clk) begin
      if (!rst_n) begin
         instr_ack <= 1'b0;
      end else if (instr_ack) begin
         instr_ack <= instr_req;
      end else begin
         instr_ack <= de_load;
      end
   end

endmodule

/* source/execute_stage.sv */
module execute_stage (
   input  logic              clk,
   input  logic              rst_n,
   input  logic              ex_load,
   input  logic              wb_load,
   // From decode
   input  pipe_pkg::alu_op_t op,
   input  logic              imm_sel,
   input  pipe_pkg::word_t   imm_ext,
   input  pipe_pkg::reg_id_t dr,
   // From the register file
   input  pipe_pkg::word_t   rd_data1,
   input  pipe_pkg::word_t   rd_data2,
   // Destinations in flight
   output pipe_pkg::reg_id_t ex_dr,
   output pipe_pkg::reg_id_t wb_dr,
   output pipe_pkg::word_t   wb_data
);

   pipe_pkg::word_t   a_q;
   pipe_pkg::word_t   b_q;
   pipe_pkg::alu_op_t op_q;
   pipe_pkg::word_t   alu_result;

   logic [pipe_pkg::shamt_w-1:0] shamt;

   // Operand latch, b is the immediate or sr2
   always_ff @(posedge clk) begin
      if (!rst_n) begin
         a_q   <= '0;
         b_q   <= '0;
         op_q  <= pipe_pkg::add;
         ex_dr <= '0;
      end else if (ex_load) begin
         a_q   <= rd_data1;
         b_q   <= imm_sel ? imm_ext : rd_data2;
         op_q  <= op;
         ex_dr <= dr;
      end
   end

   assign shamt = b_q[pipe_pkg::shamt_w-1:0];

   always_comb begin
      case (op_q)
         pipe_pkg::add:    alu_result = a_q + b_q;
         pipe_pkg::sub:    alu_result = a_q - b_q;
         pipe_pkg::and_op: alu_result = a_q & b_q;
         pipe_pkg::or_op:  alu_result = a_q | b_q;
         pipe_pkg::xor_op: alu_result = a_q ^ b_q;
         pipe_pkg::shl:    alu_result = a_q << shamt;
         // Logical shift, zero fill
         pipe_pkg::shr:    alu_result = a_q >> shamt;
         pipe_pkg::mov:    alu_result = b_q;
         default:          alu_result = b_q;
      endcase
   end

   // Result latch, held until the result handshake completes
   always_ff @(posedge clk) begin
      if (!rst_n) begin
         wb_dr   <= '0;
         wb_data <= '0;
      end else if (wb_load) begin
         wb_dr   <= ex_dr;
         wb_data <= alu_result;
      end
   end

endmodule

/* source/decode_stage.sv */
module decode_stage (
   input  logic              clk,
   input  logic              rst_n,
   input  logic              de_load,
   input  pipe_pkg::instr_t  instr,
   output pipe_pkg::reg_id_t sr1,
   output pipe_pkg::reg_id_t sr2,
   output pipe_pkg::reg_id_t dr,
   output logic              imm_sel,
   output pipe_pkg::alu_op_t op,
   output pipe_pkg::word_t   imm_ext
);

   pipe_pkg::instr_t instr_q;

   logic [pipe_pkg::imm_w-1:0] imm;

   // Decode latch
   always_ff @(posedge clk) begin
      if (!rst_n) begin
         instr_q <= '0;
      end else if (de_load) begin
         instr_q <= instr;
      end
   end

   // Field extraction
   assign imm_sel = instr_q[pipe_pkg::imm_sel_bit];
   assign op      = pipe_pkg::alu_op_t'(instr_q[pipe_pkg::op_hi:pipe_pkg::op_lo]);
   assign dr      = instr_q[pipe_pkg::dr_hi:pipe_pkg::dr_lo];
   assign sr1     = instr_q[pipe_pkg::sr1_hi:pipe_pkg::sr1_lo];
   assign sr2     = instr_q[pipe_pkg::sr2_hi:pipe_pkg::sr2_lo];
   assign imm     = instr_q[pipe_pkg::imm_hi:pipe_pkg::imm_lo];

   // Sign extend to a full word
   assign imm_ext = {{(pipe_pkg::xlen - pipe_pkg::imm_w){imm[pipe_pkg::imm_w-1]}}, imm};

endmodule

/* source/register_file.sv */
module register_file (
   input  logic              clk,
   input  logic              rst_n,
   input  pipe_pkg::reg_id_t rd_id1,
   input  pipe_pkg::reg_id_t rd_id2,
   output pipe_pkg::word_t   rd_data1,
   output pipe_pkg::word_t   rd_data2,
   input  logic              we,
   input  pipe_pkg::reg_id_t wr_id,
   input  pipe_pkg::word_t   wr_data
);

   pipe_pkg::word_t regs [pipe_pkg::reg_count];

   // Two asynchronous read ports
   assign rd_data1 = regs[rd_id1];
   assign rd_data2 = regs[rd_id2];

   // Single write port from writeback
   always_ff @(posedge clk) begin
      if (!rst_n) begin
         for (int i = 0; i < pipe_pkg::reg_count; i++) begin
            regs[i] <= '0;
         end
      end else if (we) begin
         regs[wr_id] <= wr_data;
      end
   end

endmodule

/* source/pipe_pkg.sv */
package pipe_pkg;

   // Datapath sizes
   localparam int xlen      = 32;
   localparam int reg_count = 8;
   localparam int reg_id_w  = $clog2(reg_count);
   localparam int imm_w     = 16;
   localparam int shamt_w   = $clog2(xlen);

   typedef logic [xlen-1:0]     word_t;
   typedef logic [reg_id_w-1:0] reg_id_t;
   typedef logic [31:0]         instr_t;

   // Instruction word layout, bits 18..16 are unused
   localparam int imm_sel_bit = 31;
   localparam int op_hi       = 30;
   localparam int op_lo       = 28;
   localparam int dr_hi       = 27;
   localparam int dr_lo       = 25;
   localparam int sr1_hi      = 24;
   localparam int sr1_lo      = 22;
   localparam int sr2_hi      = 21;
   localparam int sr2_lo      = 19;
   localparam int imm_hi      = 15;
   localparam int imm_lo      = 0;

   // ALU operations, operand a is sr1 and operand b is sr2 or the
   // sign-extended immediate
   //   add      a + b, modulo 2^32
   //   sub      a - b, modulo 2^32
   //   and_op   a & b
   //   or_op    a | b
   //   xor_op   a ^ b
   //   shl      a shifted left by b[4:0]
   //   shr      a shifted right by b[4:0], zero fill
   //   mov      b
   // Every instruction writes its result to dr
   typedef enum logic [2:0] {
      add    = 3'd0,
      sub    = 3'd1,
      and_op = 3'd2,
      or_op  = 3'd3,
      xor_op = 3'd4,
      shl    = 3'd5,
      shr    = 3'd6,
      mov    = 3'd7
   } alu_op_t;

endpackage
